//--- design/l2_pkg.sv
package l2_pkg;

    // processor side block address, bits 1:0 already dropped
    localparam int addr_width = 30;
    // memory side block address, set and tag only
    localparam int mem_addr_width = 28;
    localparam int block_width = 128;

    // address split, set in bits 6:2 and tag in bits 29:7
    localparam int set_bits = 5;
    localparam int num_sets = 32;
    localparam int tag_width = 23;

    localparam int num_ways = 2;

    // miss handling FSM
    typedef enum logic [1:0] {
        st_idle,
        st_writeback,
        st_fetch
    } l2_state_e;

    // command held by the memory port
    typedef enum logic [1:0] {
        mop_none,
        mop_read,
        mop_write
    } mem_op_e;

endpackage

//--- design/l2_lookup_if.sv
interface l2_lookup_if;

    // lookup request from the controller
    logic [l2_pkg::set_bits-1:0]  set;
    logic [l2_pkg::tag_width-1:0] tag;
    logic                         req;

    // state updates
    logic                         touch;
    logic                         mark_dirty;
    logic                         fill_we;
    logic                         fill_way;
    logic [l2_pkg::tag_width-1:0] fill_tag;

    // lookup result
    logic                         hit;
    logic                         hit_way;
    logic                         victim_way;
    logic                         victim_dirty;
    logic [l2_pkg::tag_width-1:0] victim_tag;

    modport ctrl (
        output set, tag, req, touch, mark_dirty, fill_we, fill_way, fill_tag,
        input  hit, hit_way, victim_way, victim_dirty, victim_tag
    );

    modport tags (
        input  set, tag, req, touch, mark_dirty, fill_we, fill_way, fill_tag,
        output hit, hit_way, victim_way, victim_dirty, victim_tag
    );

endinterface

//--- design/l2_tag_array.sv
module l2_tag_array (
    input logic       clk,
    input logic       proc_reset,
    l2_lookup_if.tags lookup
);

    logic [l2_pkg::tag_width-1:0] tag_mem [l2_pkg::num_ways][l2_pkg::num_sets];
    logic [l2_pkg::num_sets-1:0]  valid   [l2_pkg::num_ways];
    logic [l2_pkg::num_sets-1:0]  dirty   [l2_pkg::num_ways];
    // way to replace next in each set
    logic [l2_pkg::num_sets-1:0]  lru;
    logic [l2_pkg::num_ways-1:0]  way_hit;

    always_comb begin
        for (int w = 0; w < l2_pkg::num_ways; w++) begin
            way_hit[w] = lookup.req && valid[w][lookup.set] &&
                         (tag_mem[w][lookup.set] == lookup.tag);
        end
    end

    assign lookup.hit     = |way_hit;
    assign lookup.hit_way = way_hit[1];

    // victim is always the lru way
    assign lookup.victim_way   = lru[lookup.set];
    assign lookup.victim_dirty = dirty[lookup.victim_way][lookup.set];
    assign lookup.victim_tag   = tag_mem[lookup.victim_way][lookup.set];

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            for (int w = 0; w < l2_pkg::num_ways; w++) begin
                valid[w] <= '0;
                dirty[w] <= '0;
            end
            lru <= '0;
        end else begin
            // fill lands clean
            if (lookup.fill_we) begin
                valid[lookup.fill_way][lookup.set] <= 1'b1;
                dirty[lookup.fill_way][lookup.set] <= 1'b0;
            end
            if (lookup.mark_dirty) begin
                dirty[lookup.hit_way][lookup.set] <= 1'b1;
            end
            // point away from the way just used
            if (lookup.touch) begin
                lru[lookup.set] <= ~lookup.hit_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup.fill_we) begin
            tag_mem[lookup.fill_way][lookup.set] <= lookup.fill_tag;
        end
    end

    a_one_way_hits: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(&way_hit)
    );

    // a fill never overwrites the way the request already hits
    a_fill_misses: assert property (
        @(posedge clk) disable iff (proc_reset)
        lookup.fill_we |-> !lookup.hit
    );

endmodule

//--- design/l2_data_array.sv
module l2_data_array (
    input  logic                          clk,
    input  logic [l2_pkg::set_bits-1:0]    set,
    input  logic                          rd_way,
    input  logic                          victim_way,
    input  logic                          we,
    input  logic                          wr_way,
    input  logic                          wr_from_mem,
    input  logic [l2_pkg::block_width-1:0] proc_wdata,
    input  logic [l2_pkg::block_width-1:0] mem_rdata,
    output logic [l2_pkg::block_width-1:0] rdata,
    output logic [l2_pkg::block_width-1:0] victim_data
);

    logic [l2_pkg::block_width-1:0] data_mem [l2_pkg::num_ways][l2_pkg::num_sets];
    logic [l2_pkg::block_width-1:0] wr_data;

    // hit read for the processor
    assign rdata = data_mem[rd_way][set];

    // writeback source
    assign victim_data = data_mem[victim_way][set];

    // fill from memory or processor store
    assign wr_data = wr_from_mem ? mem_rdata : proc_wdata;

    always_ff @(posedge clk) begin
        if (we) begin
            data_mem[wr_way][set] <= wr_data;
        end
    end

endmodule

//--- design/l2_mem_port.sv
module l2_mem_port (
    input  logic                              clk,
    input  logic                              proc_reset,
    input  logic                              load,
    input  l2_pkg::mem_op_e                   op,
    input  logic [l2_pkg::mem_addr_width-1:0] addr,
    input  logic [l2_pkg::block_width-1:0]    wdata,
    output logic                              done,
    output logic                              mem_read,
    output logic                              mem_write,
    output logic [l2_pkg::mem_addr_width-1:0] mem_addr,
    output logic [l2_pkg::block_width-1:0]    mem_wdata,
    input  logic                              mem_ready
);

    logic busy;

    assign busy = mem_read | mem_write;

    // transfer ends in the ready cycle
    assign done = busy & mem_ready;

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end else if (load) begin
            mem_read  <= (op == l2_pkg::mop_read);
            mem_write <= (op == l2_pkg::mop_write);
        end else if (done) begin
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            mem_addr  <= addr;
            mem_wdata <= wdata;
        end
    end

    a_req_stable: assert property (
        @(posedge clk) disable iff (proc_reset)
        busy && !mem_ready |=> busy && $stable(mem_addr) && $stable(mem_wdata)
    );

    // next command only when idle or the current one finishes now
    a_no_load_busy: assert property (
        @(posedge clk) disable iff (proc_reset)
        load |-> !busy || mem_ready
    );

endmodule

//--- design/l2_ctrl.sv
module l2_ctrl (
    input  logic                              clk,
    input  logic                              proc_reset,
    input  logic                              proc_read,
    input  logic                              proc_write,
    input  logic [l2_pkg::addr_width-1:0]     proc_addr,
    output logic                              proc_stall,
    l2_lookup_if.ctrl                         lookup,
    output logic                              data_we,
    output logic                              data_wr_way,
    output logic                              data_from_mem,
    output logic                              mem_load,
    output l2_pkg::mem_op_e                   mem_op,
    output logic [l2_pkg::mem_addr_width-1:0] mem_addr_req,
    input  logic                              mem_done
);

    l2_pkg::l2_state_e                 state;
    l2_pkg::l2_state_e                 state_next;
    logic                              req;
    logic                              in_idle;
    logic                              write_hit;
    logic                              fill;
    logic [l2_pkg::mem_addr_width-1:0] req_block;

    assign req       = proc_read | proc_write;
    assign in_idle   = (state == l2_pkg::st_idle);
    assign req_block = proc_addr[l2_pkg::addr_width-1:2];

    assign lookup.req = req;
    assign lookup.set = proc_addr[l2_pkg::set_bits+1:2];
    assign lookup.tag = proc_addr[l2_pkg::addr_width-1:l2_pkg::set_bits+2];

    assign proc_stall = req & ~lookup.hit;

    assign write_hit = in_idle & proc_write & lookup.hit;
    // block lands at the edge where memory answers the fetch
    assign fill = (state == l2_pkg::st_fetch) & mem_done;

    assign lookup.touch      = in_idle & lookup.hit;
    assign lookup.mark_dirty = write_hit;
    assign lookup.fill_we    = fill;
    assign lookup.fill_way   = lookup.victim_way;
    assign lookup.fill_tag   = lookup.tag;

    assign data_we       = write_hit | fill;
    assign data_wr_way   = fill ? lookup.victim_way : lookup.hit_way;
    assign data_from_mem = fill;

    always_comb begin
        state_next   = state;
        mem_load     = 1'b0;
        mem_op       = l2_pkg::mop_none;
        mem_addr_req = req_block;
        case (state)
            l2_pkg::st_idle: begin
                if (proc_stall) begin
                    mem_load = 1'b1;
                    // dirty victim goes out first
                    if (lookup.victim_dirty) begin
                        mem_op       = l2_pkg::mop_write;
                        mem_addr_req = {lookup.victim_tag, lookup.set};
                        state_next   = l2_pkg::st_writeback;
                    end else begin
                        mem_op     = l2_pkg::mop_read;
                        state_next = l2_pkg::st_fetch;
                    end
                end
            end
            l2_pkg::st_writeback: begin
                if (mem_done) begin
                    mem_load   = 1'b1;
                    mem_op     = l2_pkg::mop_read;
                    state_next = l2_pkg::st_fetch;
                end
            end
            l2_pkg::st_fetch: begin
                if (mem_done) begin
                    state_next = l2_pkg::st_idle;
                end
            end
            default: begin
                state_next = l2_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state <= l2_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

    // processor keeps its request steady through a stall
    a_req_held: assert property (
        @(posedge clk) disable iff (proc_reset)
        proc_stall |=> req && $stable(proc_addr)
    );

endmodule

//--- design/l2_dcache.sv
module l2_dcache (
    input  logic                              clk,
    input  logic                              proc_reset,
    input  logic                              proc_read,
    input  logic                              proc_write,
    input  logic [l2_pkg::addr_width-1:0]     proc_addr,
    input  logic [l2_pkg::block_width-1:0]    proc_wdata,
    output logic                              proc_stall,
    output logic [l2_pkg::block_width-1:0]    proc_rdata,
    output logic                              mem_read,
    output logic                              mem_write,
    output logic [l2_pkg::mem_addr_width-1:0] mem_addr,
    input  logic [l2_pkg::block_width-1:0]    mem_rdata,
    output logic [l2_pkg::block_width-1:0]    mem_wdata,
    input  logic                              mem_ready
);

    logic                              data_we;
    logic                              data_wr_way;
    logic                              data_from_mem;
    logic                              mem_load;
    l2_pkg::mem_op_e                   mem_op;
    logic [l2_pkg::mem_addr_width-1:0] mem_addr_req;
    logic                              mem_done;
    logic [l2_pkg::block_width-1:0]    victim_data;

    l2_lookup_if lookup ();

    l2_ctrl u_ctrl (
        .clk           (clk),
        .proc_reset    (proc_reset),
        .proc_read     (proc_read),
        .proc_write    (proc_write),
        .proc_addr     (proc_addr),
        .proc_stall    (proc_stall),
        .lookup        (lookup.ctrl),
        .data_we       (data_we),
        .data_wr_way   (data_wr_way),
        .data_from_mem (data_from_mem),
        .mem_load      (mem_load),
        .mem_op        (mem_op),
        .mem_addr_req  (mem_addr_req),
        .mem_done      (mem_done)
    );

    l2_tag_array u_tags (
        .clk        (clk),
        .proc_reset (proc_reset),
        .lookup     (lookup.tags)
    );

    l2_data_array u_data (
        .clk         (clk),
        .set         (lookup.set),
        .rd_way      (lookup.hit_way),
        .victim_way  (lookup.victim_way),
        .we          (data_we),
        .wr_way      (data_wr_way),
        .wr_from_mem (data_from_mem),
        .proc_wdata  (proc_wdata),
        .mem_rdata   (mem_rdata),
        .rdata       (proc_rdata),
        .victim_data (victim_data)
    );

    l2_mem_port u_mem_port (
        .clk        (clk),
        .proc_reset (proc_reset),
        .load       (mem_load),
        .op         (mem_op),
        .addr       (mem_addr_req),
        .wdata      (victim_data),
        .done       (mem_done),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready)
    );

endmodule

//--- tb/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic proc_reset
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period  = 5;
    localparam int reset_cycles = 8;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        proc_reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        proc_reset <= 1'b0;
    end

endmodule

//--- tb/tb_mem_model.sv
module tb_mem_model (
    input  logic                              clk,
    input  logic                              proc_reset,
    input  logic                              mem_read,
    input  logic                              mem_write,
    input  logic [l2_pkg::mem_addr_width-1:0] mem_addr,
    input  logic [l2_pkg::block_width-1:0]    mem_wdata,
    output logic [l2_pkg::block_width-1:0]    mem_rdata,
    output logic                              mem_ready,
    output int                                rd_count,
    output int                                wr_count,
    output int                                rd_seq,
    output int                                wr_seq,
    output logic [l2_pkg::mem_addr_width-1:0] last_rd_addr,
    output logic [l2_pkg::mem_addr_width-1:0] last_wr_addr,
    output logic [l2_pkg::block_width-1:0]    last_wr_data,
    output logic                              stable_err
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [l2_pkg::block_width-1:0] store [logic [l2_pkg::mem_addr_width-1:0]];

    // untouched blocks hold their own address, repeated
    function automatic logic [l2_pkg::block_width-1:0] read_block(
        logic [l2_pkg::mem_addr_width-1:0] a);
        if (store.exists(a)) begin
            return store[a];
        end
        return {4{4'h0, a}};
    endfunction

    initial begin
        bit                                pending;
        int                                wait_cnt;
        int                                seq;
        logic [l2_pkg::mem_addr_width-1:0] held_addr;
        logic [l2_pkg::block_width-1:0]    held_wdata;
        logic                              held_write;
        pending      = 1'b0;
        wait_cnt     = 0;
        seq          = 0;
        mem_ready    = 1'b0;
        mem_rdata    = '0;
        rd_count     = 0;
        wr_count     = 0;
        rd_seq       = 0;
        wr_seq       = 0;
        last_rd_addr = '0;
        last_wr_addr = '0;
        last_wr_data = '0;
        stable_err   = 1'b0;
        forever begin
            @(posedge clk);
            if (proc_reset) begin
                pending = 1'b0;
                mem_ready <= 1'b0;
            end else if (mem_ready) begin
                // transfer ends at this edge
                mem_ready <= 1'b0;
            end else if (mem_read || mem_write) begin
                if (!pending) begin
                    pending    = 1'b1;
                    wait_cnt   = int'($urandom % 6);
                    held_addr  = mem_addr;
                    held_wdata = mem_wdata;
                    held_write = mem_write;
                end else if (mem_addr !== held_addr || mem_wdata !== held_wdata ||
                             mem_write !== held_write) begin
                    stable_err <= 1'b1;
                end
                if (wait_cnt == 0) begin
                    pending = 1'b0;
                    seq     = seq + 1;
                    mem_ready <= 1'b1;
                    if (mem_write) begin
                        store[mem_addr] = mem_wdata;
                        wr_count     <= wr_count + 1;
                        wr_seq       <= seq;
                        last_wr_addr <= mem_addr;
                        last_wr_data <= mem_wdata;
                    end else begin
                        mem_rdata    <= read_block(mem_addr);
                        rd_count     <= rd_count + 1;
                        rd_seq       <= seq;
                        last_rd_addr <= mem_addr;
                    end
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end
        end
    end

endmodule

//--- tb/tb_l2_dcache.sv
module tb_l2_dcache;
    timeunit 1ns;
    timeprecision 100ps;

    localparam string stim_file     = "tb/l2_stimulus.txt";
    localparam int    cycles_per_op = 200;
    localparam int    reset_cycles  = 8;

    logic                              clk;
    logic                              proc_reset;
    logic                              proc_read;
    logic                              proc_write;
    logic [l2_pkg::addr_width-1:0]     proc_addr;
    logic [l2_pkg::block_width-1:0]    proc_wdata;
    logic                              proc_stall;
    logic [l2_pkg::block_width-1:0]    proc_rdata;
    logic                              mem_read;
    logic                              mem_write;
    logic [l2_pkg::mem_addr_width-1:0] mem_addr;
    logic [l2_pkg::block_width-1:0]    mem_rdata;
    logic [l2_pkg::block_width-1:0]    mem_wdata;
    logic                              mem_ready;
    int                                rd_count;
    int                                wr_count;
    int                                rd_seq;
    int                                wr_seq;
    logic [l2_pkg::mem_addr_width-1:0] last_rd_addr;
    logic [l2_pkg::mem_addr_width-1:0] last_wr_addr;
    logic [l2_pkg::block_width-1:0]    last_wr_data;
    logic                              stable_err;
    bit                                loaded;

    // one entry per stimulus line
    bit                                op_write   [$];
    logic [l2_pkg::addr_width-1:0]     op_addr    [$];
    logic [l2_pkg::block_width-1:0]    op_wdata   [$];
    logic [l2_pkg::block_width-1:0]    op_rdata   [$];
    int                                op_reads   [$];
    int                                op_writes  [$];
    logic [l2_pkg::mem_addr_width-1:0] op_wb_addr [$];

    // last processor write per block
    logic [l2_pkg::block_width-1:0] ref_store [logic [l2_pkg::mem_addr_width-1:0]];

    tb_clock_gen clk_gen (.clk(clk), .proc_reset(proc_reset));

    tb_mem_model mem (
        .clk(clk), .proc_reset(proc_reset), .mem_read(mem_read), .mem_write(mem_write),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
        .mem_ready(mem_ready), .rd_count(rd_count), .wr_count(wr_count), .rd_seq(rd_seq),
        .wr_seq(wr_seq), .last_rd_addr(last_rd_addr), .last_wr_addr(last_wr_addr),
        .last_wr_data(last_wr_data), .stable_err(stable_err)
    );

    l2_dcache uut (
        .clk(clk), .proc_reset(proc_reset), .proc_read(proc_read), .proc_write(proc_write),
        .proc_addr(proc_addr), .proc_wdata(proc_wdata), .proc_stall(proc_stall),
        .proc_rdata(proc_rdata), .mem_read(mem_read), .mem_write(mem_write),
        .mem_addr(mem_addr), .mem_rdata(mem_rdata), .mem_wdata(mem_wdata),
        .mem_ready(mem_ready)
    );

    task automatic stop_on_failure(string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string name, logic [127:0] actual, logic [127:0] expected);
        if (actual !== expected) begin
            stop_on_failure($sformatf("error at %0.1f ns: %s is %h, expected %h",
                                      $realtime, name, actual, expected));
        end
    endtask

    function automatic logic [l2_pkg::block_width-1:0] expected_block(
        logic [l2_pkg::mem_addr_width-1:0] a);
        if (ref_store.exists(a)) begin
            return ref_store[a];
        end
        return {4{4'h0, a}};
    endfunction

    task automatic load_stimulus();
        int                                fd;
        int                                n;
        string                             line;
        int                                wr;
        int                                nr;
        int                                nw;
        logic [l2_pkg::addr_width-1:0]     a;
        logic [l2_pkg::block_width-1:0]    wd;
        logic [l2_pkg::block_width-1:0]    rd;
        logic [l2_pkg::mem_addr_width-1:0] wb;
        fd = $fopen(stim_file, "r");
        if (fd == 0) begin
            stop_on_failure($sformatf("cannot open the stimulus file %s", stim_file));
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%d %h %h %h %d %d %h", wr, a, wd, rd, nr, nw, wb);
                    if (n == 7) begin
                        op_write.push_back(wr != 0);
                        op_addr.push_back(a);
                        op_wdata.push_back(wd);
                        op_rdata.push_back(rd);
                        op_reads.push_back(nr);
                        op_writes.push_back(nw);
                        op_wb_addr.push_back(wb);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_op(int i);
        int                                stall_cycles;
        int                                rd0;
        int                                wr0;
        logic [l2_pkg::mem_addr_width-1:0] blk;
        blk          = op_addr[i][l2_pkg::addr_width-1:2];
        rd0          = rd_count;
        wr0          = wr_count;
        stall_cycles = 0;
        @(posedge clk);
        proc_read  <= !op_write[i];
        proc_write <= op_write[i];
        proc_addr  <= op_addr[i];
        proc_wdata <= op_wdata[i];
        @(negedge clk);
        while (proc_stall) begin
            stall_cycles++;
            @(negedge clk);
        end
        if (!op_write[i]) begin
            check_value("proc_rdata", proc_rdata, op_rdata[i]);
        end
        check_value("mem_read count", 128'(rd_count - rd0), 128'(op_reads[i]));
        check_value("mem_write count", 128'(wr_count - wr0), 128'(op_writes[i]));
        if (op_reads[i] == 0) begin
            check_value("proc_stall cycles", 128'(stall_cycles), 128'(0));
        end else begin
            check_value("mem_addr of fetch", 128'(last_rd_addr), 128'(blk));
        end
        if (op_writes[i] != 0) begin
            check_value("mem_addr of writeback", 128'(last_wr_addr), 128'(op_wb_addr[i]));
            check_value("mem_wdata of writeback", last_wr_data, expected_block(op_wb_addr[i]));
            check_value("writeback before fetch", 128'(wr_seq < rd_seq), 128'(1));
        end
        check_value("memory request stable", 128'(stable_err), 128'(0));
        if (op_write[i]) begin
            ref_store[blk] = op_wdata[i];
        end
    endtask

    initial begin
        void'($urandom(23));
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        load_stimulus();
        if (op_addr.size() == 0) begin
            stop_on_failure("the stimulus file holds no operations");
        end
        loaded = 1'b1;
        wait (!proc_reset);
        for (int i = 0; i < op_addr.size(); i++) begin
            run_op(i);
        end
        @(posedge clk);
        proc_read  <= 1'b0;
        proc_write <= 1'b0;
        @(posedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // watchdog scaled by the number of operations
    initial begin
        wait (loaded);
        repeat (op_addr.size() * cycles_per_op + reset_cycles) @(posedge clk);
        stop_on_failure("timeout: the cache stopped making progress and the run hangs");
    end

endmodule

//--- tb/l2_stimulus.txt
# op (0 read, 1 write), proc address, write data, expected read data,
# fetches, writebacks, writeback block address; all hex except op and the counts
0 00000288 00000000000000000000000000000000 000000a2000000a2000000a2000000a2 1 0 0000000
0 00000288 00000000000000000000000000000000 000000a2000000a2000000a2000000a2 0 0 0000000
1 00000288 11111111222222223333333344444444 00000000000000000000000000000000 0 0 0000000
0 00000288 00000000000000000000000000000000 11111111222222223333333344444444 0 0 0000000
1 0000008c 0123456789abcdef0011223344556677 00000000000000000000000000000000 1 0 0000000
0 0000008c 00000000000000000000000000000000 0123456789abcdef0011223344556677 0 0 0000000
0 00000004 00000000000000000000000000000000 00000001000000010000000100000001 1 0 0000000
1 00000084 fedcba9876543210ffeeddccbbaa9988 00000000000000000000000000000000 1 0 0000000
0 00000004 00000000000000000000000000000000 00000001000000010000000100000001 0 0 0000000
0 00000104 00000000000000000000000000000000 00000041000000410000004100000041 1 1 0000021
0 00000004 00000000000000000000000000000000 00000001000000010000000100000001 0 0 0000000
0 00000084 00000000000000000000000000000000 fedcba9876543210ffeeddccbbaa9988 1 0 0000000
0 00000308 00000000000000000000000000000000 000000c2000000c2000000c2000000c2 1 0 0000000
1 00000388 c0c0c0c0c1c1c1c1c2c2c2c2c3c3c3c3 00000000000000000000000000000000 1 1 00000a2
0 00000288 00000000000000000000000000000000 11111111222222223333333344444444 1 0 0000000
0 00000388 00000000000000000000000000000000 c0c0c0c0c1c1c1c1c2c2c2c2c3c3c3c3 0 0 0000000
1 00000288 d0d0d0d0d1d1d1d1d2d2d2d2d3d3d3d3 00000000000000000000000000000000 0 0 0000000
0 00000308 00000000000000000000000000000000 000000c2000000c2000000c2000000c2 1 1 00000e2
0 00000288 00000000000000000000000000000000 d0d0d0d0d1d1d1d1d2d2d2d2d3d3d3d3 0 0 0000000
0 00000388 00000000000000000000000000000000 c0c0c0c0c1c1c1c1c2c2c2c2c3c3c3c3 1 0 0000000

//--- filelist.f
design/l2_pkg.sv
design/l2_lookup_if.sv
design/l2_tag_array.sv
design/l2_data_array.sv
design/l2_mem_port.sv
design/l2_ctrl.sv
design/l2_dcache.sv
tb/tb_clock_gen.sv
tb/tb_mem_model.sv
tb/tb_l2_dcache.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_l2_dcache
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
